/* dv/tb_cdh_checks.svh */
//--------------------------------------------------------------------------
// Testbench check helpers, included inside the testbench module
// Error and timeout counters, typed compare tasks,
// bounded wait on the debounced jumper output
//--------------------------------------------------------------------------
`ifndef TB_CDH_CHECKS_SVH
`define TB_CDH_CHECKS_SVH

// Failure counters, reported in the closing line
int err_count     = 0;
int timeout_count = 0;

// Single serial line or control level
task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		err_count = err_count + 1;
		$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

// Whole jumper vector
task automatic check_jumpers(input string name, input jumper_vec_t got, input jumper_vec_t exp);
	if (got !== exp)
	begin
		err_count = err_count + 1;
		$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

// Wait for the debounced jumpers to reach a value, one cycle per step
task automatic wait_jumpers(input jumper_vec_t exp, input int max_cycles,
	output int cycles, output bit ok);
	int  n;
	bit  seen;
	n    = 0;
	seen = 1'b0;
	while (!seen && n < max_cycles)
	begin
		@(posedge dco_clk);
		#10;
		n = n + 1;
		if (jumper_mcu_o === exp)
		begin
			seen = 1'b1;
		end
	end
	cycles = n;
	ok     = seen;
	if (!seen)
	begin
		timeout_count = timeout_count + 1;
		$display("Timeout: debounced jumpers did not reach 0x%0h within %0d cycles",
			exp, max_cycles);
	end
endtask

`endif

/* dv/tb_cdh_fabric.sv */
//--------------------------------------------------------------------------
// Testbench for the C&DH routing fabric
// Clock and reset, DUT instance, directed tests for debounce,
// UART routing, payload gating and flash sharing, final report
//--------------------------------------------------------------------------
`timescale 1ns/1ps

`include "cdh_config.svh"

module tb_cdh_fabric
	import cdh_pkg::*;
();

	localparam int DBL = `DB_LIMIT_DEFAULT;

	logic        dco_clk;
	logic        dco_rst;
	jumper_vec_t jumper_i;
	jumper_vec_t jumper_mcu_o;
	gpio_word_t  gpio_i;

	// Processor TX and connector RX
	logic mcu_console_txd_i, mcu_dbg_txd_i, mcu_app_txd_i;
	logic fp_console_txd_i, fp_dbg_txd_i, fp_radio_txd_i, fp_payload_txd_i;
	logic ext_console_rxd_i, ext_dbg_rxd_i, umb_rxd_i, payload_rxd_i;

	// Routed outputs
	logic ext_console_txd_o, ext_dbg_txd_o, umb_txd_o, payload_txd_o, payload_pwr_o;
	logic mcu_console_rxd_o, mcu_dbg_rxd_o, mcu_dbg_en_o, mcu_app_rxd_o;
	logic fp_console_rxd_o, fp_dbg_rxd_o, fp_radio_rxd_o, fp_payload_rxd_o;

	// Flash masters and pins
	logic mcu_sck_i, mcu_csn_i, mcu_mosi_i, fp_sck_i, fp_csn_i, fp_mosi_i;
	logic flash_miso_i, mcu_miso_o, fp_miso_o, flash_sck_o, flash_csn_o, flash_mosi_o;

	`include "tb_cdh_checks.svh"

	cdh_fabric_top dut_i
	(
		.dco_clk           (dco_clk),
		.dco_rst           (dco_rst),
		.jumper_i          (jumper_i),
		.jumper_mcu_o      (jumper_mcu_o),
		.gpio_i            (gpio_i),
		.mcu_console_txd_i (mcu_console_txd_i),
		.mcu_dbg_txd_i     (mcu_dbg_txd_i),
		.mcu_app_txd_i     (mcu_app_txd_i),
		.fp_console_txd_i  (fp_console_txd_i),
		.fp_dbg_txd_i      (fp_dbg_txd_i),
		.fp_radio_txd_i    (fp_radio_txd_i),
		.fp_payload_txd_i  (fp_payload_txd_i),
		.ext_console_rxd_i (ext_console_rxd_i),
		.ext_dbg_rxd_i     (ext_dbg_rxd_i),
		.umb_rxd_i         (umb_rxd_i),
		.payload_rxd_i     (payload_rxd_i),
		.ext_console_txd_o (ext_console_txd_o),
		.ext_dbg_txd_o     (ext_dbg_txd_o),
		.umb_txd_o         (umb_txd_o),
		.payload_txd_o     (payload_txd_o),
		.payload_pwr_o     (payload_pwr_o),
		.mcu_console_rxd_o (mcu_console_rxd_o),
		.mcu_dbg_rxd_o     (mcu_dbg_rxd_o),
		.mcu_dbg_en_o      (mcu_dbg_en_o),
		.mcu_app_rxd_o     (mcu_app_rxd_o),
		.fp_console_rxd_o  (fp_console_rxd_o),
		.fp_dbg_rxd_o      (fp_dbg_rxd_o),
		.fp_radio_rxd_o    (fp_radio_rxd_o),
		.fp_payload_rxd_o  (fp_payload_rxd_o),
		.mcu_sck_i         (mcu_sck_i),
		.mcu_csn_i         (mcu_csn_i),
		.mcu_mosi_i        (mcu_mosi_i),
		.fp_sck_i          (fp_sck_i),
		.fp_csn_i          (fp_csn_i),
		.fp_mosi_i         (fp_mosi_i),
		.flash_miso_i      (flash_miso_i),
		.mcu_miso_o        (mcu_miso_o),
		.fp_miso_o         (fp_miso_o),
		.flash_sck_o       (flash_sck_o),
		.flash_csn_o       (flash_csn_o),
		.flash_mosi_o      (flash_mosi_o)
	);

	// 100 ns clock
	initial
	begin
		dco_clk = 1'b0;
		forever #50 dco_clk = ~dco_clk;
	end

	//----------------------------------------------------------------------
	// Stimulus helpers
	//----------------------------------------------------------------------

	// Drive point 10 ns past the rising edge
	task automatic next_cycle();
		@(posedge dco_clk);
		#10;
	endtask

	function automatic logic rand_bit();
		int unsigned r;
		r = $urandom();
		return r[0];
	endfunction

	// Fresh random level on every UART input
	task automatic randomize_lines();
		mcu_console_txd_i = rand_bit();
		mcu_dbg_txd_i     = rand_bit();
		mcu_app_txd_i     = rand_bit();
		fp_console_txd_i  = rand_bit();
		fp_dbg_txd_i      = rand_bit();
		fp_radio_txd_i    = rand_bit();
		fp_payload_txd_i  = rand_bit();
		ext_console_rxd_i = rand_bit();
		ext_dbg_rxd_i     = rand_bit();
		umb_rxd_i         = rand_bit();
		payload_rxd_i     = rand_bit();
	endtask

	// Move the jumpers and wait until the debounced copy follows
	task automatic set_jumpers(input jumper_vec_t v);
		int cyc;
		bit ok;
		next_cycle();
		jumper_i = v;
		wait_jumpers(v, DBL + 3, cyc, ok);
	endtask

	//----------------------------------------------------------------------
	// Directed tests
	//----------------------------------------------------------------------

	task automatic reset_state();
		check_jumpers("jumper_mcu_o", jumper_mcu_o, '0);
		check_bit("mcu_dbg_en_o", mcu_dbg_en_o, 1'b1);
		check_bit("umb_txd_o", umb_txd_o, 1'b1);
		repeat (8)
		begin
			next_cycle();
			randomize_lines();
			#5;
			// Both ports default to the MCU
			check_bit("ext_console_txd_o", ext_console_txd_o, mcu_console_txd_i);
			check_bit("ext_dbg_txd_o", ext_dbg_txd_o, mcu_dbg_txd_i);
		end
	endtask

	task automatic jumper_filtering();
		jumper_vec_t v;
		int          cyc;
		bit          ok;
		v = '0;
		v[`JMP_UMBILICAL] = 1'b1;
		// Short pulse must be swallowed
		next_cycle();
		jumper_i = v;
		for (int i = 0; i < 2 * DBL; i++)
		begin
			next_cycle();
			if (i == DBL / 2 - 1)
			begin
				jumper_i = '0;
			end
			check_jumpers("jumper_mcu_o", jumper_mcu_o, '0);
		end
		// Held change accepted between DBL and DBL+3 cycles
		next_cycle();
		jumper_i = v;
		wait_jumpers(v, DBL + 3, cyc, ok);
		if (ok && cyc < DBL)
		begin
			err_count = err_count + 1;
			$display("Debounce accepted a jumper change after only %0d cycles", cyc);
		end
		set_jumpers('0);
	endtask

	task automatic console_debug_routing();
		jumper_vec_t v;
		logic        con_s;
		logic        dbg_s;
		// Console and debug selects walked independently
		for (int s = 0; s < 4; s++)
		begin
			con_s = s[0];
			dbg_s = s[1];
			v = '0;
			v[`JMP_CONSOLE] = con_s;
			v[`JMP_DEBUG]   = dbg_s;
			set_jumpers(v);
			repeat (8)
			begin
				next_cycle();
				randomize_lines();
				#5;
				check_bit("mcu_dbg_en_o", mcu_dbg_en_o, ~dbg_s);
				if (con_s)
				begin
					check_bit("ext_console_txd_o", ext_console_txd_o, fp_console_txd_i);
					check_bit("fp_console_rxd_o", fp_console_rxd_o, ext_console_rxd_i);
					check_bit("mcu_console_rxd_o", mcu_console_rxd_o, 1'b0);
				end
				else
				begin
					check_bit("ext_console_txd_o", ext_console_txd_o, mcu_console_txd_i);
					check_bit("mcu_console_rxd_o", mcu_console_rxd_o, ext_console_rxd_i);
					check_bit("fp_console_rxd_o", fp_console_rxd_o, 1'b0);
				end
				if (dbg_s)
				begin
					check_bit("ext_dbg_txd_o", ext_dbg_txd_o, fp_dbg_txd_i);
					check_bit("fp_dbg_rxd_o", fp_dbg_rxd_o, ext_dbg_rxd_i);
					check_bit("mcu_dbg_rxd_o", mcu_dbg_rxd_o, 1'b0);
				end
				else
				begin
					check_bit("ext_dbg_txd_o", ext_dbg_txd_o, mcu_dbg_txd_i);
					check_bit("mcu_dbg_rxd_o", mcu_dbg_rxd_o, ext_dbg_rxd_i);
					check_bit("fp_dbg_rxd_o", fp_dbg_rxd_o, 1'b0);
				end
			end
		end
	endtask

	task automatic umbilical_routing();
		jumper_vec_t v;
		for (int s = 0; s < 2; s++)
		begin
			v = '0;
			v[`JMP_UMBILICAL] = s[0];
			set_jumpers(v);
			repeat (8)
			begin
				next_cycle();
				randomize_lines();
				#5;
				if (s[0])
				begin
					check_bit("umb_txd_o", umb_txd_o, fp_radio_txd_i);
					check_bit("fp_radio_rxd_o", fp_radio_rxd_o, umb_rxd_i);
					check_bit("mcu_app_rxd_o", mcu_app_rxd_o, 1'b0);
				end
				else
				begin
					// Radio mode crosses FP and MCU app UART
					check_bit("umb_txd_o", umb_txd_o, 1'b1);
					check_bit("fp_radio_rxd_o", fp_radio_rxd_o, mcu_app_txd_i);
					check_bit("mcu_app_rxd_o", mcu_app_rxd_o, fp_radio_txd_i);
				end
			end
		end
	endtask

	task automatic payload_gating();
		logic pwr_b;
		logic uart_b;
		for (int combo = 0; combo < 4; combo++)
		begin
			pwr_b  = combo[0];
			uart_b = combo[1];
			repeat (4)
			begin
				next_cycle();
				// Other GPIO bits random and without effect
				gpio_i = gpio_word_t'($urandom());
				gpio_i[`GPIO_PAYLOAD_PWR]  = pwr_b;
				gpio_i[`GPIO_PAYLOAD_UART] = uart_b;
				randomize_lines();
				#5;
				check_bit("payload_pwr_o", payload_pwr_o, pwr_b);
				if (uart_b)
				begin
					check_bit("payload_txd_o", payload_txd_o, fp_payload_txd_i);
					check_bit("fp_payload_rxd_o", fp_payload_rxd_o, payload_rxd_i);
				end
				else
				begin
					check_bit("payload_txd_o", payload_txd_o, 1'b1);
					check_bit("fp_payload_rxd_o", fp_payload_rxd_o, 1'b0);
				end
			end
		end
	endtask

	task automatic flash_sharing();
		for (int owner = 0; owner < 2; owner++)
		begin
			repeat (8)
			begin
				next_cycle();
				mcu_sck_i    = rand_bit();
				mcu_mosi_i   = rand_bit();
				fp_sck_i     = rand_bit();
				fp_csn_i     = rand_bit();
				fp_mosi_i    = rand_bit();
				flash_miso_i = rand_bit();
				// Owner 0 is the MCU with its select low
				mcu_csn_i = (owner == 0) ? 1'b0 : 1'b1;
				#5;
				if (owner == 0)
				begin
					check_bit("flash_sck_o", flash_sck_o, mcu_sck_i);
					check_bit("flash_csn_o", flash_csn_o, 1'b0);
					check_bit("flash_mosi_o", flash_mosi_o, mcu_mosi_i);
					check_bit("mcu_miso_o", mcu_miso_o, flash_miso_i);
					check_bit("fp_miso_o", fp_miso_o, 1'b0);
				end
				else
				begin
					check_bit("flash_sck_o", flash_sck_o, fp_sck_i);
					check_bit("flash_csn_o", flash_csn_o, fp_csn_i);
					check_bit("flash_mosi_o", flash_mosi_o, fp_mosi_i);
					check_bit("fp_miso_o", fp_miso_o, flash_miso_i);
					check_bit("mcu_miso_o", mcu_miso_o, 1'b0);
				end
			end
		end
	endtask

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------

	initial
	begin
		void'($urandom(32'h3c139be4));
		dco_rst  = 1'b1;
		jumper_i = '0;
		gpio_i   = '0;
		randomize_lines();
		mcu_sck_i    = 1'b0;
		mcu_csn_i    = 1'b1;
		mcu_mosi_i   = 1'b0;
		fp_sck_i     = 1'b0;
		fp_csn_i     = 1'b1;
		fp_mosi_i    = 1'b0;
		flash_miso_i = 1'b0;
		repeat (5) @(posedge dco_clk);
		#10;
		dco_rst = 1'b0;

		reset_state();
		jumper_filtering();
		console_debug_routing();
		umbilical_routing();
		payload_gating();
		flash_sharing();

		$display("Errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
		begin
			$display("Simulation completed successfully");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the C&DH fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f vlog.f \
	--top-module tb_cdh_fabric \
	-Mdir obj_dir \
	-o sim_tb

# Keep going after a nonzero exit so the log can be searched
status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
	echo "Testbench reported failure"
	exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
	echo "Simulation ended without a result (exit status $status)"
	exit 1
fi

exit 0

/* src/cdh_config.svh */
//--------------------------------------------------------------------------
// Build-time constants for the C&DH routing fabric
// Jumper count and bit positions, FP GPIO width and bit roles,
// debounce limit and counter width
//--------------------------------------------------------------------------
`ifndef CDH_CONFIG_SVH
`define CDH_CONFIG_SVH

// Board jumpers
`define N_JUMPERS           5

// Bit position of each jumper in the jumper vector
`define JMP_UMBILICAL       0
`define JMP_FLASH           1
`define JMP_BYPASS          2
`define JMP_DEBUG           3
`define JMP_CONSOLE         4

// FP GPIO output word
`define LEON_GPIO_W         14
`define GPIO_PAYLOAD_PWR    0
`define GPIO_PAYLOAD_UART   1

// Stable cycles before a jumper change is accepted
// Short value for simulation, hardware uses a much longer window
`define DB_LIMIT_DEFAULT    16
`define DB_CNT_W            5

`endif

/* src/cdh_fabric_top.sv */
//--------------------------------------------------------------------------
// C&DH signal-routing fabric, top level
// Jumper conditioning feeding the UART routing stage,
// configuration flash arbiter alongside
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cdh_fabric_top
	import cdh_pkg::*;
(
	input  logic        dco_clk,
	input  logic        dco_rst,

	// Jumpers, raw in and debounced out to the MCU
	input  jumper_vec_t jumper_i,
	output jumper_vec_t jumper_mcu_o,

	// FP GPIO word
	input  gpio_word_t  gpio_i,

	// Processor UART TX
	input  logic        mcu_console_txd_i,
	input  logic        mcu_dbg_txd_i,
	input  logic        mcu_app_txd_i,
	input  logic        fp_console_txd_i,
	input  logic        fp_dbg_txd_i,
	input  logic        fp_radio_txd_i,
	input  logic        fp_payload_txd_i,

	// Connector UART RX
	input  logic        ext_console_rxd_i,
	input  logic        ext_dbg_rxd_i,
	input  logic        umb_rxd_i,
	input  logic        payload_rxd_i,

	// Connector side outputs
	output logic        ext_console_txd_o,
	output logic        ext_dbg_txd_o,
	output logic        umb_txd_o,
	output logic        payload_txd_o,
	output logic        payload_pwr_o,

	// MCU side outputs
	output logic        mcu_console_rxd_o,
	output logic        mcu_dbg_rxd_o,
	output logic        mcu_dbg_en_o,
	output logic        mcu_app_rxd_o,

	// FP side outputs
	output logic        fp_console_rxd_o,
	output logic        fp_dbg_rxd_o,
	output logic        fp_radio_rxd_o,
	output logic        fp_payload_rxd_o,

	// Configuration flash masters and pins
	input  logic        mcu_sck_i,
	input  logic        mcu_csn_i,
	input  logic        mcu_mosi_i,
	input  logic        fp_sck_i,
	input  logic        fp_csn_i,
	input  logic        fp_mosi_i,
	input  logic        flash_miso_i,
	output logic        mcu_miso_o,
	output logic        fp_miso_o,
	output logic        flash_sck_o,
	output logic        flash_csn_o,
	output logic        flash_mosi_o
);

	// Conditioned jumpers, shared by routing and MCU
	jumper_vec_t jumper_db;

	assign jumper_mcu_o = jumper_db;

	//----------------------------------------------------------------------
	// Stage 1, jumper conditioning
	//----------------------------------------------------------------------

	jumper_debounce u_jumper_debounce
	(
		.dco_clk      (dco_clk),
		.dco_rst      (dco_rst),
		.jumper_raw_i (jumper_i),
		.jumper_db_o  (jumper_db)
	);

	//----------------------------------------------------------------------
	// Stage 2, UART routing
	//----------------------------------------------------------------------

	uart_route u_uart_route
	(
		.sel_i             (jumper_db),
		.gpio_i            (gpio_i),
		.mcu_console_txd_i (mcu_console_txd_i),
		.mcu_dbg_txd_i     (mcu_dbg_txd_i),
		.mcu_app_txd_i     (mcu_app_txd_i),
		.fp_console_txd_i  (fp_console_txd_i),
		.fp_dbg_txd_i      (fp_dbg_txd_i),
		.fp_radio_txd_i    (fp_radio_txd_i),
		.fp_payload_txd_i  (fp_payload_txd_i),
		.ext_console_rxd_i (ext_console_rxd_i),
		.ext_dbg_rxd_i     (ext_dbg_rxd_i),
		.umb_rxd_i         (umb_rxd_i),
		.payload_rxd_i     (payload_rxd_i),
		.ext_console_txd_o (ext_console_txd_o),
		.ext_dbg_txd_o     (ext_dbg_txd_o),
		.umb_txd_o         (umb_txd_o),
		.payload_txd_o     (payload_txd_o),
		.payload_pwr_o     (payload_pwr_o),
		.mcu_console_rxd_o (mcu_console_rxd_o),
		.mcu_dbg_rxd_o     (mcu_dbg_rxd_o),
		.mcu_dbg_en_o      (mcu_dbg_en_o),
		.mcu_app_rxd_o     (mcu_app_rxd_o),
		.fp_console_rxd_o  (fp_console_rxd_o),
		.fp_dbg_rxd_o      (fp_dbg_rxd_o),
		.fp_radio_rxd_o    (fp_radio_rxd_o),
		.fp_payload_rxd_o  (fp_payload_rxd_o)
	);

	//----------------------------------------------------------------------
	// Configuration flash, beside the routing stage
	//----------------------------------------------------------------------

	conflash_arbiter u_conflash_arbiter
	(
		.mcu_sck_i    (mcu_sck_i),
		.mcu_csn_i    (mcu_csn_i),
		.mcu_mosi_i   (mcu_mosi_i),
		.fp_sck_i     (fp_sck_i),
		.fp_csn_i     (fp_csn_i),
		.fp_mosi_i    (fp_mosi_i),
		.flash_miso_i (flash_miso_i),
		.mcu_miso_o   (mcu_miso_o),
		.fp_miso_o    (fp_miso_o),
		.flash_sck_o  (flash_sck_o),
		.flash_csn_o  (flash_csn_o),
		.flash_mosi_o (flash_mosi_o)
	);

endmodule

/* src/cdh_pkg.sv */
//--------------------------------------------------------------------------
// Shared vector types for the C&DH routing fabric
// Jumper vector, FP GPIO word, debounce counter value
//--------------------------------------------------------------------------
`include "cdh_config.svh"

package cdh_pkg;

	//----------------------------------------------------------------------
	// Board-level vectors
	//----------------------------------------------------------------------

	// One bit per jumper, indexed by the JMP_* positions
	typedef logic [`N_JUMPERS-1:0] jumper_vec_t;

	// FP GPIO output word
	// Bit 0 payload power, bit 1 payload UART enable
	typedef logic [`LEON_GPIO_W-1:0] gpio_word_t;

	//----------------------------------------------------------------------
	// Debounce
	//----------------------------------------------------------------------

	// Per-jumper stability count, saturates at the limit
	typedef logic [`DB_CNT_W-1:0] db_count_t;

endpackage

/* src/conflash_arbiter.sv */
//--------------------------------------------------------------------------
// Configuration SPI flash sharing
// MCU wins whenever its chip select is low, FP otherwise
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module conflash_arbiter
(
	// MCU flash master
	input  logic mcu_sck_i,
	input  logic mcu_csn_i,
	input  logic mcu_mosi_i,

	// FP flash master
	input  logic fp_sck_i,
	input  logic fp_csn_i,
	input  logic fp_mosi_i,

	// Flash data out
	input  logic flash_miso_i,

	// MISO back to each master
	output logic mcu_miso_o,
	output logic fp_miso_o,

	// Flash pins
	output logic flash_sck_o,
	output logic flash_csn_o,
	output logic flash_mosi_o
);

	// MCU owns the flash while its select is asserted
	logic mcu_owns;

	assign mcu_owns = ~mcu_csn_i;

	//----------------------------------------------------------------------
	// Pin mux
	//----------------------------------------------------------------------

	// Select low toward the pin when MCU owns it
	assign flash_sck_o  = mcu_owns ? mcu_sck_i  : fp_sck_i;
	assign flash_csn_o  = mcu_owns ? mcu_csn_i  : fp_csn_i;
	assign flash_mosi_o = mcu_owns ? mcu_mosi_i : fp_mosi_i;

	// Only the owner hears the flash
	assign mcu_miso_o = mcu_owns ? flash_miso_i : 1'b0;
	assign fp_miso_o  = mcu_owns ? 1'b0 : flash_miso_i;

endmodule

/* src/jumper_debounce.sv */
//--------------------------------------------------------------------------
// Jumper conditioning stage
// Two-flop synchronizer per jumper, stability counter per jumper,
// debounced jumper register
//--------------------------------------------------------------------------
`timescale 1ns/1ps

`include "cdh_config.svh"

module jumper_debounce
	import cdh_pkg::*;
#(
	parameter int N        = `N_JUMPERS,
	parameter int DB_LIMIT = `DB_LIMIT_DEFAULT
)
(
	input  logic        dco_clk,
	input  logic        dco_rst,

	// Raw jumper pins, asynchronous to dco_clk
	input  jumper_vec_t jumper_raw_i,

	// Conditioned jumper levels
	output jumper_vec_t jumper_db_o
);

	// Count value at which a bit is taken over
	localparam db_count_t DB_CNT = db_count_t'(DB_LIMIT);

	//----------------------------------------------------------------------
	// Synchronizer
	//----------------------------------------------------------------------

	// First and second metastability flops
	jumper_vec_t sync1_q;
	jumper_vec_t sync2_q;

	// Debounced value
	jumper_vec_t db_q;

	always_ff @(posedge dco_clk or posedge dco_rst)
	begin
		if (dco_rst)
		begin
			sync1_q <= '0;
			sync2_q <= '0;
		end
		else
		begin
			sync1_q <= jumper_raw_i;
			sync2_q <= sync1_q;
		end
	end

	//----------------------------------------------------------------------
	// Stability counters, one per jumper
	//----------------------------------------------------------------------

	for (genvar i = 0; i < N; i++)
	begin : g_bit
		db_count_t cnt_q;

		always_ff @(posedge dco_clk or posedge dco_rst)
		begin
			if (dco_rst)
			begin
				cnt_q   <= '0;
				db_q[i] <= 1'b0;
			end
			else
			begin
				// New level seen, this sample is the first stable one
				if (sync1_q[i] != sync2_q[i])
				begin
					cnt_q <= db_count_t'(1);
				end
				else if (cnt_q != DB_CNT)
				begin
					cnt_q <= cnt_q + db_count_t'(1);
				end

				// Held long enough, take it
				if (cnt_q == DB_CNT)
				begin
					db_q[i] <= sync2_q[i];
				end
			end
		end
	end

	assign jumper_db_o = db_q;

endmodule

/* src/uart_route.sv */
//--------------------------------------------------------------------------
// Routing stage for all board UARTs
// Console and debug steering between MCU and FP, umbilical versus
// MCU radio link, payload UART gate and payload power
//--------------------------------------------------------------------------
`timescale 1ns/1ps

`include "cdh_config.svh"

module uart_route
	import cdh_pkg::*;
(
	// Debounced jumpers and FP GPIO word
	input  jumper_vec_t sel_i,
	input  gpio_word_t  gpio_i,

	// Transmit lines from the processors
	input  logic        mcu_console_txd_i,
	input  logic        mcu_dbg_txd_i,
	input  logic        mcu_app_txd_i,
	input  logic        fp_console_txd_i,
	input  logic        fp_dbg_txd_i,
	input  logic        fp_radio_txd_i,
	input  logic        fp_payload_txd_i,

	// Receive lines from the connectors
	input  logic        ext_console_rxd_i,
	input  logic        ext_dbg_rxd_i,
	input  logic        umb_rxd_i,
	input  logic        payload_rxd_i,

	// Connector side
	output logic        ext_console_txd_o,
	output logic        ext_dbg_txd_o,
	output logic        umb_txd_o,
	output logic        payload_txd_o,
	output logic        payload_pwr_o,

	// MCU side
	output logic        mcu_console_rxd_o,
	output logic        mcu_dbg_rxd_o,
	output logic        mcu_dbg_en_o,
	output logic        mcu_app_rxd_o,

	// FP side
	output logic        fp_console_rxd_o,
	output logic        fp_dbg_rxd_o,
	output logic        fp_radio_rxd_o,
	output logic        fp_payload_rxd_o
);

	// Select bits, high means the FP owns the link
	logic con_sel;
	logic dbg_sel;
	logic umb_sel;

	// Payload UART gate from FP GPIO
	logic pl_en;

	assign con_sel = sel_i[`JMP_CONSOLE];
	assign dbg_sel = sel_i[`JMP_DEBUG];
	assign umb_sel = sel_i[`JMP_UMBILICAL];
	assign pl_en   = gpio_i[`GPIO_PAYLOAD_UART];

	//----------------------------------------------------------------------
	// Console and debug, one external port shared by MCU and FP
	//----------------------------------------------------------------------

	// Unselected side sees a held-low RX
	assign ext_console_txd_o = con_sel ? fp_console_txd_i : mcu_console_txd_i;
	assign fp_console_rxd_o  = con_sel ? ext_console_rxd_i : 1'b0;
	assign mcu_console_rxd_o = con_sel ? 1'b0 : ext_console_rxd_i;

	assign ext_dbg_txd_o = dbg_sel ? fp_dbg_txd_i : mcu_dbg_txd_i;
	assign fp_dbg_rxd_o  = dbg_sel ? ext_dbg_rxd_i : 1'b0;
	assign mcu_dbg_rxd_o = dbg_sel ? 1'b0 : ext_dbg_rxd_i;

	// MCU debug interface only active while it owns the port
	assign mcu_dbg_en_o = ~dbg_sel;

	//----------------------------------------------------------------------
	// FP command/telemetry link
	//----------------------------------------------------------------------

	// Umbilical mode: FP talks to the header, MCU app UART idle low
	// Radio mode: FP and MCU cross-connected, header TX idles high
	assign umb_txd_o      = umb_sel ? fp_radio_txd_i : 1'b1;
	assign fp_radio_rxd_o = umb_sel ? umb_rxd_i : mcu_app_txd_i;
	assign mcu_app_rxd_o  = umb_sel ? 1'b0 : fp_radio_txd_i;

	//----------------------------------------------------------------------
	// Payload
	//----------------------------------------------------------------------

	// Gated off: line idles high toward the payload
	assign payload_txd_o    = pl_en ? fp_payload_txd_i : 1'b1;
	assign fp_payload_rxd_o = pl_en ? payload_rxd_i : 1'b0;

	// Power switch straight from GPIO
	assign payload_pwr_o = gpio_i[`GPIO_PAYLOAD_PWR];

endmodule

/* vlog.f */
+incdir+src
+incdir+dv
src/cdh_pkg.sv
src/jumper_debounce.sv
src/uart_route.sv
src/conflash_arbiter.sv
src/cdh_fabric_top.sv
dv/tb_cdh_fabric.sv
